// File: src/isa_pkg.sv
package isa_pkg;

	localparam int WORD_W     = 32;
	localparam int DWORD_W    = 2 * WORD_W;
	localparam int REG_ADDR_W = 5;
	localparam int ALUOP_W    = 8;
	localparam int ALUSEL_W   = 3;

	// logic
	localparam logic [ALUOP_W-1:0] OP_AND   = 8'b0010_0100;
	localparam logic [ALUOP_W-1:0] OP_OR    = 8'b0010_0101;
	localparam logic [ALUOP_W-1:0] OP_XOR   = 8'b0010_0110;
	localparam logic [ALUOP_W-1:0] OP_NOR   = 8'b0010_0111;
	// shifts
	localparam logic [ALUOP_W-1:0] OP_SLL   = 8'b0111_1100;
	localparam logic [ALUOP_W-1:0] OP_SRL   = 8'b0000_0010;
	localparam logic [ALUOP_W-1:0] OP_SRA   = 8'b0000_0011;
	// arithmetic and compare
	localparam logic [ALUOP_W-1:0] OP_SLT   = 8'b0010_1010;
	localparam logic [ALUOP_W-1:0] OP_SLTU  = 8'b0010_1011;
	localparam logic [ALUOP_W-1:0] OP_ADD   = 8'b0010_0000;
	localparam logic [ALUOP_W-1:0] OP_ADDU  = 8'b0010_0001;
	localparam logic [ALUOP_W-1:0] OP_SUB   = 8'b0010_0010;
	localparam logic [ALUOP_W-1:0] OP_SUBU  = 8'b0010_0011;
	localparam logic [ALUOP_W-1:0] OP_ADDI  = 8'b0101_0101;
	localparam logic [ALUOP_W-1:0] OP_ADDIU = 8'b0101_0110;
	localparam logic [ALUOP_W-1:0] OP_CLZ   = 8'b1011_0000;
	localparam logic [ALUOP_W-1:0] OP_CLO   = 8'b1011_0001;
	// multiply, accumulate, divide
	localparam logic [ALUOP_W-1:0] OP_MULT  = 8'b0001_1000;
	localparam logic [ALUOP_W-1:0] OP_MULTU = 8'b0001_1001;
	localparam logic [ALUOP_W-1:0] OP_MUL   = 8'b1010_1001;
	localparam logic [ALUOP_W-1:0] OP_MADD  = 8'b1010_0110;
	localparam logic [ALUOP_W-1:0] OP_MADDU = 8'b1010_1000;
	localparam logic [ALUOP_W-1:0] OP_MSUB  = 8'b1010_1010;
	localparam logic [ALUOP_W-1:0] OP_MSUBU = 8'b1010_1011;
	localparam logic [ALUOP_W-1:0] OP_DIV   = 8'b0001_1010;
	localparam logic [ALUOP_W-1:0] OP_DIVU  = 8'b0001_1011;
	// hi/lo moves
	localparam logic [ALUOP_W-1:0] OP_MFHI  = 8'b0001_0000;
	localparam logic [ALUOP_W-1:0] OP_MTHI  = 8'b0001_0001;
	localparam logic [ALUOP_W-1:0] OP_MFLO  = 8'b0001_0010;
	localparam logic [ALUOP_W-1:0] OP_MTLO  = 8'b0001_0011;

	localparam logic [ALUSEL_W-1:0] SEL_NOP   = 3'b000;
	localparam logic [ALUSEL_W-1:0] SEL_LOGIC = 3'b001;
	localparam logic [ALUSEL_W-1:0] SEL_SHIFT = 3'b010;
	localparam logic [ALUSEL_W-1:0] SEL_MOVE  = 3'b011;
	localparam logic [ALUSEL_W-1:0] SEL_ARITH = 3'b100;
	localparam logic [ALUSEL_W-1:0] SEL_MUL   = 3'b101;

	localparam int DIV_STEPS    = 32;
	localparam int DIV_CNT_W    = $clog2(DIV_STEPS);
	localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS - 1);
	localparam int DIV_LATENCY  = 34;
	localparam int MADD_LATENCY = 2;

endpackage

// File: src/exec_pkg.sv
package exec_pkg;

	// one issued operation
	typedef struct packed {
		logic [isa_pkg::ALUOP_W-1:0]    aluop;
		logic [isa_pkg::ALUSEL_W-1:0]   alusel;
		logic [isa_pkg::WORD_W-1:0]     reg1;
		logic [isa_pkg::WORD_W-1:0]     reg2;
		logic [isa_pkg::REG_ADDR_W-1:0] wd;
		logic                           wreg;
	} ex_req_t;

	typedef struct packed {
		logic [isa_pkg::REG_ADDR_W-1:0] wd;
		logic                           wreg;
		logic [isa_pkg::WORD_W-1:0]     wdata;
		logic                           ov;
	} ex_res_t;

	typedef struct packed {
		logic [isa_pkg::WORD_W-1:0] hi;
		logic [isa_pkg::WORD_W-1:0] lo;
	} hilo_t;

	typedef struct packed {
		logic  we;
		hilo_t value;
	} hilo_wr_t;

	// gpr variant returns the low word only and leaves hi/lo alone
	typedef enum logic [1:0] {
		MUL_PLAIN,
		MUL_ACC,
		MUL_SUB,
		MUL_GPR
	} mul_mode_t;

endpackage

// File: src/int_alu.sv
`timescale 1ns/1ps

module int_alu (
	input  logic [isa_pkg::ALUOP_W-1:0] aluop_i,
	input  logic [isa_pkg::WORD_W-1:0]  a_i,
	input  logic [isa_pkg::WORD_W-1:0]  b_i,
	output logic [isa_pkg::WORD_W-1:0]  logic_o,
	output logic [isa_pkg::WORD_W-1:0]  shift_o,
	output logic [isa_pkg::WORD_W-1:0]  arith_o,
	output logic                        ov_o
);

	logic                       is_sub;
	logic [isa_pkg::WORD_W-1:0] b_mux;
	logic [isa_pkg::WORD_W-1:0] sum;
	logic                       lt;

	// leading count of ones, 32 when the word is all ones
	function automatic logic [5:0] lead_ones(input logic [isa_pkg::WORD_W-1:0] w);
		logic [5:0] n;
		logic       hit;
		n   = 6'd32;
		hit = 1'b0;
		for (int i = isa_pkg::WORD_W - 1; i >= 0; i--) begin
			if (!hit && !w[i]) begin
				n   = 6'(isa_pkg::WORD_W - 1 - i);
				hit = 1'b1;
			end
		end
		return n;
	endfunction

	always_comb begin
		case (aluop_i)
			isa_pkg::OP_OR:  logic_o = a_i | b_i;
			isa_pkg::OP_AND: logic_o = a_i & b_i;
			isa_pkg::OP_NOR: logic_o = ~(a_i | b_i);
			isa_pkg::OP_XOR: logic_o = a_i ^ b_i;
			default:         logic_o = '0;
		endcase
	end

	// shift amount from a, value from b
	always_comb begin
		case (aluop_i)
			isa_pkg::OP_SLL: shift_o = b_i << a_i[4:0];
			isa_pkg::OP_SRL: shift_o = b_i >> a_i[4:0];
			isa_pkg::OP_SRA: shift_o = $unsigned($signed(b_i) >>> a_i[4:0]);
			default:         shift_o = '0;
		endcase
	end

	assign is_sub = (aluop_i == isa_pkg::OP_SUB) || (aluop_i == isa_pkg::OP_SUBU);
	assign b_mux  = is_sub ? ~b_i + 1'b1 : b_i;
	assign sum    = a_i + b_mux;

	// overflow from operand signs, taken before negating b
	assign ov_o = is_sub ? ((a_i[31] ^ b_i[31]) & (sum[31] ^ a_i[31]))
		: (~(a_i[31] ^ b_i[31]) & (sum[31] ^ a_i[31]));

	assign lt = (aluop_i == isa_pkg::OP_SLT) ? ($signed(a_i) < $signed(b_i)) : (a_i < b_i);

	always_comb begin
		case (aluop_i)
			isa_pkg::OP_SLT, isa_pkg::OP_SLTU: arith_o = {31'd0, lt};
			isa_pkg::OP_ADD, isa_pkg::OP_ADDU, isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU,
			isa_pkg::OP_SUB, isa_pkg::OP_SUBU: arith_o = sum;
			isa_pkg::OP_CLZ: arith_o = {26'd0, lead_ones(~a_i)};
			isa_pkg::OP_CLO: arith_o = {26'd0, lead_ones(a_i)};
			default:         arith_o = '0;
		endcase
	end

endmodule

// File: src/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       start_i,
	input  logic                       signed_i,
	input  exec_pkg::mul_mode_t        mode_i,
	input  logic [isa_pkg::WORD_W-1:0] a_i,
	input  logic [isa_pkg::WORD_W-1:0] b_i,
	input  exec_pkg::hilo_t            hilo_i,
	output logic [isa_pkg::WORD_W-1:0] lo_o,
	output logic                       done_o,
	output exec_pkg::hilo_wr_t         wr_o
);

	logic [isa_pkg::WORD_W-1:0]  a_mag;
	logic [isa_pkg::WORD_W-1:0]  b_mag;
	logic [isa_pkg::DWORD_W-1:0] prod_mag;
	logic [isa_pkg::DWORD_W-1:0] prod;
	logic [isa_pkg::DWORD_W-1:0] prod_q;
	logic [isa_pkg::DWORD_W-1:0] hilo_new;
	logic                        neg;
	logic                        acc_q;
	logic                        sub_q;
	logic                        acc_start;

	// signed multiply on magnitudes, sign applied to the product
	assign a_mag    = (signed_i && a_i[31]) ? -a_i : a_i;
	assign b_mag    = (signed_i && b_i[31]) ? -b_i : b_i;
	assign prod_mag = {32'd0, a_mag} * {32'd0, b_mag};
	assign neg      = signed_i && (a_i[31] ^ b_i[31]);
	assign prod     = neg ? -prod_mag : prod_mag;
	assign lo_o     = prod[isa_pkg::WORD_W-1:0];

	assign acc_start = start_i && (mode_i == exec_pkg::MUL_ACC || mode_i == exec_pkg::MUL_SUB);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			acc_q <= 1'b0;
			sub_q <= 1'b0;
		end else begin
			acc_q <= acc_start;
			if (acc_start) begin
				sub_q <= (mode_i == exec_pkg::MUL_SUB);
			end
		end
	end

	// product held one cycle before the accumulate
	always_ff @(posedge clk) begin
		if (acc_start) begin
			prod_q <= prod;
		end
	end

	assign hilo_new = sub_q ? {hilo_i.hi, hilo_i.lo} - prod_q : {hilo_i.hi, hilo_i.lo} + prod_q;

	assign done_o = acc_q ||
		(start_i && (mode_i == exec_pkg::MUL_PLAIN || mode_i == exec_pkg::MUL_GPR));

	always_comb begin
		wr_o.we       = acc_q || (start_i && mode_i == exec_pkg::MUL_PLAIN);
		wr_o.value.hi = acc_q ? hilo_new[63:32] : prod[63:32];
		wr_o.value.lo = acc_q ? hilo_new[31:0] : prod[31:0];
	end

endmodule

// File: src/div_unit.sv
`timescale 1ns/1ps

module div_unit (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       start_i,
	input  logic                       signed_i,
	input  logic [isa_pkg::WORD_W-1:0] a_i,
	input  logic [isa_pkg::WORD_W-1:0] b_i,
	output logic                       done_o,
	output exec_pkg::hilo_wr_t         wr_o
);

	logic                          run_q;
	logic                          fix_q;
	logic [isa_pkg::DIV_CNT_W-1:0] cnt_q;
	logic [isa_pkg::WORD_W-1:0]    q_q;
	logic [isa_pkg::WORD_W-1:0]    r_q;
	logic [isa_pkg::WORD_W-1:0]    d_q;
	logic                          qneg_q;
	logic                          rneg_q;
	logic                          zero_q;
	logic [isa_pkg::WORD_W-1:0]    a_mag;
	logic [isa_pkg::WORD_W-1:0]    b_mag;
	logic [isa_pkg::WORD_W:0]      rem_sh;
	logic [isa_pkg::WORD_W:0]      diff;
	logic [isa_pkg::WORD_W-1:0]    quot;
	logic [isa_pkg::WORD_W-1:0]    rem;

	assign a_mag  = (signed_i && a_i[31]) ? -a_i : a_i;
	assign b_mag  = (signed_i && b_i[31]) ? -b_i : b_i;
	assign rem_sh = {r_q, q_q[isa_pkg::WORD_W-1]};
	assign diff   = rem_sh - {1'b0, d_q};

	always_ff @(posedge clk) begin
		if (reset_i) begin
			run_q <= 1'b0;
			fix_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			fix_q <= run_q && (cnt_q == isa_pkg::DIV_LAST);
			if (start_i) begin
				run_q <= 1'b1;
				cnt_q <= '0;
			end else if (run_q) begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == isa_pkg::DIV_LAST) begin
					run_q <= 1'b0;
				end
			end
		end
	end

	// one restoring step per cycle, quotient bits shift in from the right
	always_ff @(posedge clk) begin
		if (start_i) begin
			q_q    <= a_mag;
			r_q    <= '0;
			d_q    <= b_mag;
			qneg_q <= signed_i && (a_i[31] ^ b_i[31]);
			rneg_q <= signed_i && a_i[31];
			zero_q <= (b_i == '0);
		end else if (run_q) begin
			q_q <= {q_q[isa_pkg::WORD_W-2:0], ~diff[isa_pkg::WORD_W]};
			r_q <= diff[isa_pkg::WORD_W] ? rem_sh[isa_pkg::WORD_W-1:0]
				: diff[isa_pkg::WORD_W-1:0];
		end
	end

	// remainder takes the dividend sign
	assign quot = qneg_q ? -q_q : q_q;
	assign rem  = rneg_q ? -r_q : r_q;

	assign done_o = fix_q;

	always_comb begin
		wr_o.we       = fix_q;
		wr_o.value.hi = zero_q ? '0 : rem;
		wr_o.value.lo = zero_q ? '0 : quot;
	end

	a_no_restart: assert property (@(posedge clk) disable iff (reset_i)
		start_i |-> !run_q && !fix_q);

endmodule

// File: src/hilo_regs.sv
`timescale 1ns/1ps

module hilo_regs (
	input  logic               clk,
	input  logic               reset_i,
	input  exec_pkg::hilo_wr_t mul_wr_i,
	input  exec_pkg::hilo_wr_t div_wr_i,
	input  exec_pkg::hilo_wr_t mt_wr_i,
	output exec_pkg::hilo_t    hilo_o
);

	exec_pkg::hilo_t hilo_q;

	// one shared write port, strobes never overlap
	always_ff @(posedge clk) begin
		if (reset_i) begin
			hilo_q <= '0;
		end else if (mul_wr_i.we) begin
			hilo_q <= mul_wr_i.value;
		end else if (div_wr_i.we) begin
			hilo_q <= div_wr_i.value;
		end else if (mt_wr_i.we) begin
			hilo_q <= mt_wr_i.value;
		end
	end

	assign hilo_o = hilo_q;

	a_one_writer: assert property (@(posedge clk) disable iff (reset_i)
		$onehot0({mul_wr_i.we, div_wr_i.we, mt_wr_i.we}));

endmodule

// File: src/ex_control.sv
`timescale 1ns/1ps

module ex_control (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       valid_i,
	input  exec_pkg::ex_req_t          req_i,
	input  logic [isa_pkg::WORD_W-1:0] alu_logic_i,
	input  logic [isa_pkg::WORD_W-1:0] alu_shift_i,
	input  logic [isa_pkg::WORD_W-1:0] alu_arith_i,
	input  logic                       alu_ov_i,
	input  logic [isa_pkg::WORD_W-1:0] mul_lo_i,
	input  logic                       mul_done_i,
	input  logic                       div_done_i,
	input  exec_pkg::hilo_t            hilo_i,
	output logic                       mul_start_o,
	output logic                       mul_signed_o,
	output exec_pkg::mul_mode_t        mul_mode_o,
	output logic                       div_start_o,
	output logic                       div_signed_o,
	output logic [isa_pkg::WORD_W-1:0] op_a_o,
	output logic [isa_pkg::WORD_W-1:0] op_b_o,
	output exec_pkg::hilo_wr_t         mt_wr_o,
	output logic                       done_o,
	output logic                       busy_o,
	output exec_pkg::ex_res_t          res_o
);

	exec_pkg::ex_req_t          req_q;
	logic [isa_pkg::WORD_W-1:0] logic_q;
	logic [isa_pkg::WORD_W-1:0] shift_q;
	logic [isa_pkg::WORD_W-1:0] arith_q;
	logic                       ov_q;
	logic                       first_q;
	logic                       busy_q;
	logic                       is_mul;
	logic                       is_acc;
	logic                       is_div;
	logic                       is_mt;
	logic                       fin;
	logic                       ov_hit;
	logic [isa_pkg::WORD_W-1:0] wdata;

	// alu results are captured together with the request
	always_ff @(posedge clk) begin
		if (valid_i) begin
			req_q   <= req_i;
			logic_q <= alu_logic_i;
			shift_q <= alu_shift_i;
			arith_q <= alu_arith_i;
			ov_q    <= alu_ov_i;
		end
	end

	always_comb begin
		is_mul       = 1'b0;
		is_acc       = 1'b0;
		is_div       = 1'b0;
		is_mt        = 1'b0;
		mul_signed_o = 1'b0;
		div_signed_o = 1'b0;
		mul_mode_o   = exec_pkg::MUL_PLAIN;
		case (req_q.aluop)
			isa_pkg::OP_MUL: begin
				is_mul       = 1'b1;
				mul_signed_o = 1'b1;
				mul_mode_o   = exec_pkg::MUL_GPR;
			end
			isa_pkg::OP_MULT: begin
				is_mul       = 1'b1;
				mul_signed_o = 1'b1;
			end
			isa_pkg::OP_MULTU: is_mul = 1'b1;
			isa_pkg::OP_MADD, isa_pkg::OP_MADDU: begin
				is_acc       = 1'b1;
				mul_signed_o = (req_q.aluop == isa_pkg::OP_MADD);
				mul_mode_o   = exec_pkg::MUL_ACC;
			end
			isa_pkg::OP_MSUB, isa_pkg::OP_MSUBU: begin
				is_acc       = 1'b1;
				mul_signed_o = (req_q.aluop == isa_pkg::OP_MSUB);
				mul_mode_o   = exec_pkg::MUL_SUB;
			end
			isa_pkg::OP_DIV: begin
				is_div       = 1'b1;
				div_signed_o = 1'b1;
			end
			isa_pkg::OP_DIVU: is_div = 1'b1;
			isa_pkg::OP_MTHI, isa_pkg::OP_MTLO: is_mt = 1'b1;
			default: begin
			end
		endcase
	end

	assign op_a_o      = req_q.reg1;
	assign op_b_o      = req_q.reg2;
	assign mul_start_o = first_q && (is_mul || is_acc);
	assign div_start_o = first_q && is_div;

	// moves write the whole pair, keeping the other half
	always_comb begin
		mt_wr_o.we       = first_q && is_mt;
		mt_wr_o.value.hi = (req_q.aluop == isa_pkg::OP_MTHI) ? req_q.reg1 : hilo_i.hi;
		mt_wr_o.value.lo = (req_q.aluop == isa_pkg::OP_MTLO) ? req_q.reg1 : hilo_i.lo;
	end

	always_comb begin
		case (req_q.alusel)
			isa_pkg::SEL_LOGIC: wdata = logic_q;
			isa_pkg::SEL_SHIFT: wdata = shift_q;
			isa_pkg::SEL_ARITH: wdata = arith_q;
			isa_pkg::SEL_MUL:   wdata = mul_lo_i;
			isa_pkg::SEL_MOVE: begin
				if (req_q.aluop == isa_pkg::OP_MFHI) begin
					wdata = hilo_i.hi;
				end else if (req_q.aluop == isa_pkg::OP_MFLO) begin
					wdata = hilo_i.lo;
				end else begin
					wdata = '0;
				end
			end
			default: wdata = '0;
		endcase
	end

	assign ov_hit = ov_q && (req_q.aluop == isa_pkg::OP_ADD ||
		req_q.aluop == isa_pkg::OP_ADDI || req_q.aluop == isa_pkg::OP_SUB);

	// single-cycle ops and mul finish in the first cycle, others wait for their unit
	assign fin    = (first_q && !is_acc && !is_div) || (busy_q && (mul_done_i || div_done_i));
	assign busy_o = busy_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			first_q <= 1'b0;
			busy_q  <= 1'b0;
			done_o  <= 1'b0;
			res_o   <= '0;
		end else begin
			first_q <= valid_i;
			done_o  <= fin;
			if (fin) begin
				busy_q      <= 1'b0;
				res_o.wd    <= req_q.wd;
				res_o.wreg  <= req_q.wreg && !ov_hit;
				res_o.wdata <= wdata;
				res_o.ov    <= ov_hit;
			end else if (first_q) begin
				busy_q <= 1'b1;
			end
		end
	end

	a_no_issue_busy: assert property (@(posedge clk) disable iff (reset_i)
		valid_i |-> !busy_o);

	// a second done right after the first needs a fresh issue in between
	a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
		done_o && !$past(valid_i) |=> !done_o);

endmodule

// File: src/ex_top.sv
`timescale 1ns/1ps

module ex_top (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              valid_i,
	input  exec_pkg::ex_req_t req_i,
	output logic              done_o,
	output logic              busy_o,
	output exec_pkg::ex_res_t res_o,
	output exec_pkg::hilo_t   hilo_o
);

	logic                       mul_start;
	logic                       mul_signed;
	exec_pkg::mul_mode_t        mul_mode;
	logic                       mul_done;
	logic                       div_start;
	logic                       div_signed;
	logic                       div_done;
	logic                       alu_ov;
	logic [isa_pkg::WORD_W-1:0] op_a;
	logic [isa_pkg::WORD_W-1:0] op_b;
	logic [isa_pkg::WORD_W-1:0] alu_logic;
	logic [isa_pkg::WORD_W-1:0] alu_shift;
	logic [isa_pkg::WORD_W-1:0] alu_arith;
	logic [isa_pkg::WORD_W-1:0] mul_lo;
	exec_pkg::hilo_wr_t         mul_wr;
	exec_pkg::hilo_wr_t         div_wr;
	exec_pkg::hilo_wr_t         mt_wr;

	ex_control i_control (
		.clk(clk), .reset_i(reset_i), .valid_i(valid_i), .req_i(req_i),
		.alu_logic_i(alu_logic), .alu_shift_i(alu_shift), .alu_arith_i(alu_arith),
		.alu_ov_i(alu_ov), .mul_lo_i(mul_lo), .mul_done_i(mul_done),
		.div_done_i(div_done), .hilo_i(hilo_o),
		.mul_start_o(mul_start), .mul_signed_o(mul_signed), .mul_mode_o(mul_mode),
		.div_start_o(div_start), .div_signed_o(div_signed),
		.op_a_o(op_a), .op_b_o(op_b), .mt_wr_o(mt_wr),
		.done_o(done_o), .busy_o(busy_o), .res_o(res_o)
	);

	// alu sees the request as it is issued
	int_alu i_alu (
		.aluop_i(req_i.aluop), .a_i(req_i.reg1), .b_i(req_i.reg2),
		.logic_o(alu_logic), .shift_o(alu_shift), .arith_o(alu_arith), .ov_o(alu_ov)
	);

	mul_unit i_mul (
		.clk(clk), .reset_i(reset_i), .start_i(mul_start), .signed_i(mul_signed),
		.mode_i(mul_mode), .a_i(op_a), .b_i(op_b), .hilo_i(hilo_o),
		.lo_o(mul_lo), .done_o(mul_done), .wr_o(mul_wr)
	);

	div_unit i_div (
		.clk(clk), .reset_i(reset_i), .start_i(div_start), .signed_i(div_signed),
		.a_i(op_a), .b_i(op_b), .done_o(div_done), .wr_o(div_wr)
	);

	hilo_regs i_hilo (
		.clk(clk), .reset_i(reset_i), .mul_wr_i(mul_wr), .div_wr_i(div_wr),
		.mt_wr_i(mt_wr), .hilo_o(hilo_o)
	);

endmodule

// File: tests/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// model state, owned by the testbench
logic [31:0]     lcg_state;
exec_pkg::hilo_t model_hilo;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// leading bits equal to lead_bit, 32 for a uniform word
function automatic logic [5:0] count_lead(input logic [31:0] w, input logic lead_bit);
	logic [5:0] n;
	logic       stop;
	n    = 6'd0;
	stop = 1'b0;
	for (int i = 31; i >= 0; i--) begin
		if (!stop && w[i] == lead_bit) begin
			n = n + 6'd1;
		end else begin
			stop = 1'b1;
		end
	end
	return n;
endfunction

// expected result and latency, updates model_hilo
function automatic exec_pkg::ex_res_t expect_result(input exec_pkg::ex_req_t r, output int lat);
	exec_pkg::ex_res_t res;
	logic [31:0]       a;
	logic [31:0]       b;
	logic [31:0]       am;
	logic [31:0]       bm;
	logic [31:0]       qt;
	logic [31:0]       rm;
	logic [63:0]       prod;
	logic [63:0]       acc;
	logic              sg;
	logic              ov;
	a         = r.reg1;
	b         = r.reg2;
	lat       = 1;
	ov        = 1'b0;
	res.wd    = r.wd;
	res.wreg  = r.wreg;
	res.wdata = '0;
	res.ov    = 1'b0;
	sg = (r.aluop == isa_pkg::OP_MULT || r.aluop == isa_pkg::OP_MUL || r.aluop == isa_pkg::OP_MADD
		|| r.aluop == isa_pkg::OP_MSUB || r.aluop == isa_pkg::OP_DIV);
	if (sg) begin
		prod = 64'($signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b}));
	end else begin
		prod = {32'd0, a} * {32'd0, b};
	end
	acc = {model_hilo.hi, model_hilo.lo};
	case (r.aluop)
		isa_pkg::OP_OR:   res.wdata = a | b;
		isa_pkg::OP_AND:  res.wdata = a & b;
		isa_pkg::OP_NOR:  res.wdata = ~(a | b);
		isa_pkg::OP_XOR:  res.wdata = a ^ b;
		isa_pkg::OP_SLL:  res.wdata = b << a[4:0];
		isa_pkg::OP_SRL:  res.wdata = b >> a[4:0];
		// sign-extended to 64 bits, then a plain right shift
		isa_pkg::OP_SRA:  res.wdata = 32'({{32{b[31]}}, b} >> a[4:0]);
		isa_pkg::OP_ADD, isa_pkg::OP_ADDI, isa_pkg::OP_ADDU, isa_pkg::OP_ADDIU: begin
			res.wdata = a + b;
			ov = (a[31] == b[31]) && (res.wdata[31] != a[31]);
		end
		isa_pkg::OP_SUB, isa_pkg::OP_SUBU: begin
			res.wdata = a - b;
			ov = (a[31] != b[31]) && (res.wdata[31] != a[31]);
		end
		isa_pkg::OP_SLT:  res.wdata = {31'd0, $signed(a) < $signed(b)};
		isa_pkg::OP_SLTU: res.wdata = {31'd0, a < b};
		isa_pkg::OP_CLZ:  res.wdata = {26'd0, count_lead(a, 1'b0)};
		isa_pkg::OP_CLO:  res.wdata = {26'd0, count_lead(a, 1'b1)};
		isa_pkg::OP_MUL:  res.wdata = prod[31:0];
		isa_pkg::OP_MULT, isa_pkg::OP_MULTU: begin
			model_hilo.hi = prod[63:32];
			model_hilo.lo = prod[31:0];
		end
		isa_pkg::OP_MADD, isa_pkg::OP_MADDU, isa_pkg::OP_MSUB, isa_pkg::OP_MSUBU: begin
			lat = isa_pkg::MADD_LATENCY;
			if (r.aluop == isa_pkg::OP_MSUB || r.aluop == isa_pkg::OP_MSUBU) begin
				acc = acc - prod;
			end else begin
				acc = acc + prod;
			end
			model_hilo.hi = acc[63:32];
			model_hilo.lo = acc[31:0];
		end
		isa_pkg::OP_DIV, isa_pkg::OP_DIVU: begin
			lat = isa_pkg::DIV_LATENCY;
			am  = (sg && a[31]) ? -a : a;
			bm  = (sg && b[31]) ? -b : b;
			if (b == 32'd0) begin
				qt = '0;
				rm = '0;
			end else begin
				qt = am / bm;
				rm = am % bm;
				if (sg && (a[31] ^ b[31])) begin
					qt = -qt;
				end
				if (sg && a[31]) begin
					rm = -rm;
				end
			end
			model_hilo.hi = rm;
			model_hilo.lo = qt;
		end
		isa_pkg::OP_MFHI: res.wdata = model_hilo.hi;
		isa_pkg::OP_MFLO: res.wdata = model_hilo.lo;
		isa_pkg::OP_MTHI: model_hilo.hi = a;
		isa_pkg::OP_MTLO: model_hilo.lo = a;
		default: begin
		end
	endcase
	// only trapping adds and subs flag overflow
	if (ov && (r.aluop == isa_pkg::OP_ADD || r.aluop == isa_pkg::OP_ADDI
		|| r.aluop == isa_pkg::OP_SUB)) begin
		res.ov   = 1'b1;
		res.wreg = 1'b0;
	end
	return res;
endfunction

`endif

// File: tests/tb_ex.sv
`timescale 1ns/1ps

module tb_ex;

	localparam int N_OPS_MAX    = 200;
	localparam int OP_CYCLES    = 40;
	localparam int RESET_CYCLES = 10;

	logic              clk = 1'b0;
	logic              reset_i;
	logic              valid_i;
	exec_pkg::ex_req_t req_i;
	logic              done_o;
	logic              busy_o;
	exec_pkg::ex_res_t res_o;
	exec_pkg::hilo_t   hilo_o;

	exec_pkg::ex_res_t exp_res;
	exec_pkg::hilo_t   exp_hilo;
	int                exp_lat;
	int                lat;
	logic              in_flight;
	int                n_issued;
	int                n_done;
	int                n_errors;

	`include "tb_ref.svh"

	ex_top i_dut (
		.clk(clk), .reset_i(reset_i), .valid_i(valid_i), .req_i(req_i),
		.done_o(done_o), .busy_o(busy_o), .res_o(res_o), .hilo_o(hilo_o)
	);

	always #5 clk = ~clk;

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic fail_plain(input string what);
		n_errors++;
		$display("ERROR: %s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [2:0] sel_for(input logic [7:0] op);
		case (op)
			isa_pkg::OP_OR, isa_pkg::OP_AND, isa_pkg::OP_NOR, isa_pkg::OP_XOR:
				return isa_pkg::SEL_LOGIC;
			isa_pkg::OP_SLL, isa_pkg::OP_SRL, isa_pkg::OP_SRA: return isa_pkg::SEL_SHIFT;
			isa_pkg::OP_MFHI, isa_pkg::OP_MFLO: return isa_pkg::SEL_MOVE;
			isa_pkg::OP_MUL: return isa_pkg::SEL_MUL;
			isa_pkg::OP_ADD, isa_pkg::OP_ADDU, isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU,
			isa_pkg::OP_SUB, isa_pkg::OP_SUBU, isa_pkg::OP_SLT, isa_pkg::OP_SLTU,
			isa_pkg::OP_CLZ, isa_pkg::OP_CLO: return isa_pkg::SEL_ARITH;
			default: return isa_pkg::SEL_NOP;
		endcase
	endfunction

	// issue one op and wait until the compare process has seen its done
	task automatic run_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
		exec_pkg::ex_req_t r;
		logic [31:0]       rnd;
		rnd      = lcg_next();
		r.aluop  = op;
		r.alusel = sel_for(op);
		r.reg1   = a;
		r.reg2   = b;
		r.wd     = rnd[4:0];
		r.wreg   = 1'b1;
		@(posedge clk);
		exp_res  = expect_result(r, exp_lat);
		exp_hilo = model_hilo;
		req_i   <= r;
		valid_i <= 1'b1;
		n_issued++;
		@(posedge clk);
		valid_i <= 1'b0;
		wait (n_done == n_issued);
	endtask

	// compare at the falling edge, away from the registered outputs
	always @(negedge clk) begin
		if (!reset_i) begin
			if (in_flight) begin
				// lat counts edges since the issue edge
				if (lat == 0) begin
					if (busy_o !== 1'b0) begin
						fail_plain("busy_o high before the first edge after issue");
					end
				end else if (busy_o !== !done_o) begin
					fail_plain("busy_o not high while an operation is running");
				end
				if (done_o) begin
					if (lat != exp_lat) begin
						fail_plain($sformatf("done after %0d cycles, expected %0d", lat, exp_lat));
					end
					check("res_o.wd", 64'(res_o.wd), 64'(exp_res.wd));
					check("res_o.wreg", 64'(res_o.wreg), 64'(exp_res.wreg));
					check("res_o.wdata", 64'(res_o.wdata), 64'(exp_res.wdata));
					check("res_o.ov", 64'(res_o.ov), 64'(exp_res.ov));
					check("hilo_o", hilo_o, exp_hilo);
					in_flight = 1'b0;
					n_done++;
				end
				lat++;
			end else if (done_o) begin
				fail_plain("done_o rose with no operation in flight");
			end
			if (valid_i) begin
				in_flight = 1'b1;
				lat       = 0;
			end
		end
	end

	initial begin
		#((RESET_CYCLES + N_OPS_MAX * OP_CYCLES) * 10);
		$display("ERROR: timeout, the tests did not finish in time");
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [7:0]  ls_ops [7];
		logic [7:0]  ar_ops [8];
		logic [7:0]  md_ops [7];
		logic [31:0] x;
		logic [31:0] y;
		reset_i    = 1'b1;
		valid_i    = 1'b0;
		req_i      = '0;
		lcg_state  = 32'h6fd4_1302;
		model_hilo = '0;
		in_flight  = 1'b0;
		lat        = 0;
		n_issued   = 0;
		n_done     = 0;
		n_errors   = 0;
		ls_ops = '{isa_pkg::OP_OR, isa_pkg::OP_AND, isa_pkg::OP_NOR, isa_pkg::OP_XOR,
			isa_pkg::OP_SLL, isa_pkg::OP_SRL, isa_pkg::OP_SRA};
		ar_ops = '{isa_pkg::OP_ADD, isa_pkg::OP_ADDU, isa_pkg::OP_SUB, isa_pkg::OP_SUBU,
			isa_pkg::OP_SLT, isa_pkg::OP_SLTU, isa_pkg::OP_CLZ, isa_pkg::OP_CLO};
		md_ops = '{isa_pkg::OP_MULT, isa_pkg::OP_MULTU, isa_pkg::OP_MUL, isa_pkg::OP_MADD,
			isa_pkg::OP_MADDU, isa_pkg::OP_MSUB, isa_pkg::OP_MSUBU};
		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check("busy_o", 64'(busy_o), 64'd0);
		check("done_o", 64'(done_o), 64'd0);
		check("res_o", 64'(res_o), 64'd0);
		check("hilo_o", hilo_o, 64'd0);

		// logic and shift, sra also on negative words
		for (int i = 0; i < 30; i++) begin
			x = lcg_next();
			run_op(ls_ops[x % 32'd7], lcg_next(), lcg_next());
		end
		for (int i = 0; i < 4; i++) begin
			run_op(isa_pkg::OP_SRA, lcg_next(), lcg_next() | 32'h8000_0000);
		end

		// arithmetic, random then overflow corners
		for (int i = 0; i < 32; i++) begin
			run_op(ar_ops[i % 8], lcg_next(), lcg_next());
		end
		run_op(isa_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
		run_op(isa_pkg::OP_ADDI, 32'h8000_0000, 32'hffff_ffff);
		run_op(isa_pkg::OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
		run_op(isa_pkg::OP_ADDIU, 32'h8000_0000, 32'hffff_ffff);
		run_op(isa_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
		run_op(isa_pkg::OP_SUBU, 32'h8000_0000, 32'h0000_0001);
		run_op(isa_pkg::OP_SLT, 32'hffff_fff0, 32'h0000_0003);
		run_op(isa_pkg::OP_SLTU, 32'hffff_fff0, 32'h0000_0003);
		run_op(isa_pkg::OP_CLZ, 32'h0000_0000, 32'h0);
		run_op(isa_pkg::OP_CLO, 32'hffff_ffff, 32'h0);

		// multiply and accumulate, each read back
		for (int i = 0; i < 14; i++) begin
			run_op(md_ops[i % 7], lcg_next(), lcg_next());
			run_op(isa_pkg::OP_MFHI, 32'h0, 32'h0);
			run_op(isa_pkg::OP_MFLO, 32'h0, 32'h0);
		end

		// divide with random, negative and zero divisors
		// div and divu alternate in groups of four so both see every divisor kind
		for (int i = 0; i < 12; i++) begin
			x = lcg_next();
			y = lcg_next() >> (i % 20);
			if (i % 4 == 1) begin
				y = -(y & 32'hff);
			end else if (i % 4 == 3) begin
				y = 32'd0;
			end
			run_op(((i / 4) % 2 == 0) ? isa_pkg::OP_DIV : isa_pkg::OP_DIVU, x, y);
			run_op(isa_pkg::OP_MFHI, 32'h0, 32'h0);
			run_op(isa_pkg::OP_MFLO, 32'h0, 32'h0);
		end

		run_op(isa_pkg::OP_MTHI, 32'hcafe_0123, 32'h0);
		run_op(isa_pkg::OP_MFHI, 32'h0, 32'h0);
		run_op(isa_pkg::OP_MFLO, 32'h0, 32'h0);
		run_op(isa_pkg::OP_MTLO, 32'h5a5a_9876, 32'h0);
		run_op(isa_pkg::OP_MFHI, 32'h0, 32'h0);
		run_op(isa_pkg::OP_MFLO, 32'h0, 32'h0);

		repeat (3) @(posedge clk);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+tests
src/isa_pkg.sv
src/exec_pkg.sv
src/int_alu.sv
src/mul_unit.sv
src/div_unit.sv
src/hilo_regs.sv
src/ex_control.sv
src/ex_top.sv
tests/tb_ex.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex -f build.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_ex 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
	exit 0
fi
exit 1
